//--- Makefile
VERILATOR ?= verilator
TOP       ?= rx_desc_ctrl_tb
DUT_TOP   ?= rx_desc_ctrl
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= ALL TESTS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)

run: build
	./$(BUILD_DIR)/$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- design/rx_desc_ctrl.sv
module rx_desc_ctrl #(
	parameter int DESC_RAM_DWORDS = 1024,
	parameter int CLK_PERIOD_NS = 4
) (
	input  logic                 aclk,
	input  logic                 aresetn,
	input  logic                 en,
	input  rxd_pkg::host_addr_t  rdba,
	input  logic [12:0]          rdlen,
	input  rxd_pkg::host_idx_t   rdh,
	input  logic                 rdh_set,
	output rxd_pkg::host_idx_t   rdh_fb,
	input  rxd_pkg::host_idx_t   rdt,
	input  logic                 rdt_set,
	input  logic [5:0]           pthresh,
	input  logic [5:0]           hthresh,
	input  logic [5:0]           wthresh,
	input  logic [15:0]          rdtr,
	output logic                 rxt0_req,
	output rxd_pkg::host_addr_t  idma_src_addr,
	output rxd_pkg::local_addr_t idma_dst_addr,
	output rxd_pkg::byte_cnt_t   idma_bytes,
	output logic                 idma_valid,
	input  logic                 idma_ready,
	input  logic                 irpt_valid,
	output rxd_pkg::local_addr_t odma_src_addr,
	output rxd_pkg::host_addr_t  odma_dst_addr,
	output rxd_pkg::byte_cnt_t   odma_bytes,
	output logic                 odma_valid,
	input  logic                 odma_ready,
	input  logic                 orpt_valid,
	output logic [31:0]          reng_m_tdata,
	output logic                 reng_m_tvalid,
	input  logic                 reng_m_tready,
	input  logic                 reng_s_tvalid,
	input  logic                 reng_s_tlast,
	output logic                 reng_s_tready
);
	import rxd_pkg::*;

	// Ring pointer results
	host_idx_t   host_fresh;
	host_idx_t   fetch_limit;
	host_idx_t   wback_limit;
	host_addr_t  host_rd_address;
	host_addr_t  host_wb_address;
	logic        ptrs_busy;

	// Pointer and queue updates from the scheduler
	logic        curr_adv;
	host_idx_t   curr_incr;
	logic        head_adv;
	host_idx_t   head_incr;
	logic        in_enq;
	desc_cnt_t   in_enq_incr;
	logic        out_deq;
	desc_cnt_t   out_deq_incr;
	logic        wback_start;

	// Engine side queue updates
	logic        in_deq;
	logic        out_enq;

	desc_cnt_t   in_num;
	desc_cnt_t   out_num;
	desc_cnt_t   local_pending;
	desc_cnt_t   local_available;
	local_addr_t fetch_local_address;
	local_addr_t wb_local_address;
	local_addr_t eng_local_address;
	logic        flush_tmo;

	// All submodule ports share names with the signals above
	rxd_ring_regs i_ring_regs (.*);

	rxd_local_queues #(
		.DESC_RAM_DWORDS(DESC_RAM_DWORDS)
	) i_local_queues (.*);

	rxd_flush_timer #(
		.CLK_PERIOD_NS(CLK_PERIOD_NS)
	) i_flush_timer (.*);

	rxd_dma_sched #(
		.DESC_RAM_DWORDS(DESC_RAM_DWORDS)
	) i_dma_sched (.*);

	rxd_engine_dispatch i_engine_dispatch (.*);

endmodule

//--- design/rxd_dma_sched.sv
module rxd_dma_sched #(
	parameter int DESC_RAM_DWORDS = 1024
) (
	input  logic                 aclk,
	input  logic                 aresetn,
	input  logic                 en,
	input  logic [5:0]           pthresh,
	input  logic [5:0]           hthresh,
	input  logic [5:0]           wthresh,
	input  rxd_pkg::host_idx_t   host_fresh,
	input  rxd_pkg::host_idx_t   fetch_limit,
	input  rxd_pkg::host_idx_t   wback_limit,
	input  rxd_pkg::host_addr_t  host_rd_address,
	input  rxd_pkg::host_addr_t  host_wb_address,
	input  logic                 ptrs_busy,
	input  rxd_pkg::desc_cnt_t   out_num,
	input  rxd_pkg::desc_cnt_t   local_pending,
	input  rxd_pkg::desc_cnt_t   local_available,
	input  rxd_pkg::local_addr_t fetch_local_address,
	input  rxd_pkg::local_addr_t wb_local_address,
	input  logic                 flush_tmo,
	output rxd_pkg::host_addr_t  idma_src_addr,
	output rxd_pkg::local_addr_t idma_dst_addr,
	output rxd_pkg::byte_cnt_t   idma_bytes,
	output logic                 idma_valid,
	input  logic                 idma_ready,
	input  logic                 irpt_valid,
	output rxd_pkg::local_addr_t odma_src_addr,
	output rxd_pkg::host_addr_t  odma_dst_addr,
	output rxd_pkg::byte_cnt_t   odma_bytes,
	output logic                 odma_valid,
	input  logic                 odma_ready,
	input  logic                 orpt_valid,
	output logic                 curr_adv,
	output rxd_pkg::host_idx_t   curr_incr,
	output logic                 head_adv,
	output rxd_pkg::host_idx_t   head_incr,
	output logic                 in_enq,
	output rxd_pkg::desc_cnt_t   in_enq_incr,
	output logic                 out_deq,
	output rxd_pkg::desc_cnt_t   out_deq_incr,
	output logic                 wback_start,
	output logic                 rxt0_req
);
	import rxd_pkg::*;

	localparam int SLOTS = DESC_RAM_DWORDS / 4;

	fetch_state_t state;
	fetch_state_t state_next;
	desc_cnt_t    fetch_size;
	desc_cnt_t    wback_size;
	desc_cnt_t    fetch_cnt;
	desc_cnt_t    wback_cnt;
	logic         wback_go;
	logic         fetch_go;

	// Narrow a host count to the local slot range
	function automatic desc_cnt_t clamp_slots(input host_idx_t value);
		if (value > host_idx_t'(SLOTS))
			return desc_cnt_t'(SLOTS);
		return desc_cnt_t'(value);
	endfunction

	function automatic desc_cnt_t min_cnt(input desc_cnt_t a, input desc_cnt_t b);
		return (a < b) ? a : b;
	endfunction

	assign fetch_size = min_cnt(min_cnt(clamp_slots(fetch_limit), clamp_slots(host_fresh)),
		local_available);
	assign wback_size = min_cnt(clamp_slots(wback_limit), out_num);

	assign wback_go = (out_num != '0) && (out_num >= desc_cnt_t'(wthresh) || flush_tmo);
	// Prefetch by thresholds, or refill when nothing is held locally
	assign fetch_go = (local_available != '0) &&
		(((pthresh == '0 || local_pending < desc_cnt_t'(pthresh)) &&
		host_fresh > host_idx_t'(hthresh)) || (local_pending == '0 && host_fresh != '0));

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			state <= FS_IDLE;
			wback_start <= 1'b0;
		end else begin
			state <= state_next;
			wback_start <= (state == FS_READY) && (state_next == FS_WBACK);
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			FS_IDLE: begin
				if (en)
					state_next = FS_READY;
			end
			FS_READY: begin
				if (!en)
					state_next = FS_IDLE;
				else if (!ptrs_busy && wback_go)
					state_next = FS_WBACK;
				else if (!ptrs_busy && fetch_go)
					state_next = FS_SET_SIZE;
			end
			FS_WBACK: begin
				if (odma_ready)
					state_next = FS_WBACK_WAIT;
			end
			FS_WBACK_WAIT: begin
				if (orpt_valid)
					state_next = FS_DEQUEUE;
			end
			FS_DEQUEUE: state_next = FS_SETTLE;
			FS_SET_SIZE: state_next = FS_FETCH;
			FS_FETCH: begin
				if (idma_ready)
					state_next = FS_FETCH_WAIT;
			end
			FS_FETCH_WAIT: begin
				if (irpt_valid)
					state_next = FS_ENQUEUE;
			end
			FS_ENQUEUE: state_next = FS_SETTLE;
			// Pointer pipeline must drain before the next decision
			FS_SETTLE: begin
				if (!ptrs_busy)
					state_next = FS_READY;
			end
			default: state_next = FS_IDLE;
		endcase
	end

	// Command fields are captured once and held through the handshake
	always_ff @(posedge aclk) begin
		if (state == FS_READY && state_next == FS_WBACK) begin
			wback_cnt <= wback_size;
			odma_src_addr <= wb_local_address;
			odma_dst_addr <= host_wb_address;
			odma_bytes <= byte_cnt_t'(wback_size) << DESC_BYTES_LOG2;
		end
		if (state == FS_READY && state_next == FS_SET_SIZE)
			fetch_cnt <= fetch_size;
		if (state == FS_SET_SIZE) begin
			idma_src_addr <= host_rd_address;
			idma_dst_addr <= fetch_local_address;
			idma_bytes <= byte_cnt_t'(fetch_cnt) << DESC_BYTES_LOG2;
		end
	end

	assign idma_valid = (state == FS_FETCH);
	assign odma_valid = (state == FS_WBACK);

	assign in_enq = (state == FS_ENQUEUE);
	assign curr_adv = (state == FS_ENQUEUE);
	assign in_enq_incr = fetch_cnt;
	assign curr_incr = host_idx_t'(fetch_cnt);

	// Dequeue cycle directly follows the write-back report
	assign out_deq = (state == FS_DEQUEUE);
	assign head_adv = (state == FS_DEQUEUE);
	assign rxt0_req = (state == FS_DEQUEUE);
	assign out_deq_incr = wback_cnt;
	assign head_incr = host_idx_t'(wback_cnt);

endmodule

//--- design/rxd_engine_dispatch.sv
module rxd_engine_dispatch (
	input  logic                 aclk,
	input  logic                 aresetn,
	input  logic                 en,
	input  rxd_pkg::desc_cnt_t   in_num,
	input  rxd_pkg::local_addr_t eng_local_address,
	output logic [31:0]          reng_m_tdata,
	output logic                 reng_m_tvalid,
	input  logic                 reng_m_tready,
	input  logic                 reng_s_tvalid,
	input  logic                 reng_s_tlast,
	output logic                 reng_s_tready,
	output logic                 in_deq,
	output logic                 out_enq
);
	import rxd_pkg::*;

	eng_state_t state;
	eng_state_t state_next;

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn)
			state <= ES_IDLE;
		else
			state <= state_next;
	end

	always_comb begin
		state_next = state;
		case (state)
			ES_IDLE: begin
				if (en)
					state_next = ES_READY;
			end
			ES_READY: begin
				if (!en)
					state_next = ES_IDLE;
				else if (in_num != '0)
					state_next = ES_CMD;
			end
			ES_CMD: begin
				if (reng_m_tready)
					state_next = ES_DEQUEUE;
			end
			ES_DEQUEUE: state_next = ES_WAIT;
			// One descriptor in the engine at a time
			ES_WAIT: begin
				if (reng_s_tvalid && reng_s_tlast)
					state_next = ES_ENQUEUE;
			end
			ES_ENQUEUE: state_next = ES_READY;
			default: state_next = ES_IDLE;
		endcase
	end

	// Head slot address only moves on in_deq, so it holds during the command
	assign reng_m_tdata = {16'h0000, eng_local_address};
	assign reng_m_tvalid = (state == ES_CMD);
	assign in_deq = (state == ES_DEQUEUE);
	assign reng_s_tready = (state == ES_WAIT);
	assign out_enq = (state == ES_ENQUEUE);

endmodule

//--- design/rxd_flush_timer.sv
module rxd_flush_timer #(
	parameter int CLK_PERIOD_NS = 4
) (
	input  logic        aclk,
	input  logic        aresetn,
	input  logic [15:0] rdtr,
	input  logic        out_enq,
	input  logic        wback_start,
	output logic        flush_tmo
);

	localparam int TICK_CYCLES = 1024 / CLK_PERIOD_NS;
	localparam int PRE_BITS = $clog2(TICK_CYCLES + 1);

	logic [PRE_BITS-1:0] prescale;
	logic                tick;
	logic [15:0]         timer;

	// 1024 ns tick, restarted by each completion
	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			prescale <= '0;
			tick <= 1'b0;
		end else if (out_enq || prescale == PRE_BITS'(TICK_CYCLES - 1)) begin
			prescale <= '0;
			tick <= !out_enq;
		end else begin
			prescale <= prescale + 1'b1;
			tick <= 1'b0;
		end
	end

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			timer <= '0;
			flush_tmo <= 1'b0;
		end else begin
			if (out_enq)
				timer <= rdtr;
			else if (wback_start)
				timer <= '0;
			else if (tick && timer != '0)
				timer <= timer - 1'b1;

			// Zero delay flushes on the completion itself
			if ((out_enq && rdtr == '0) || (tick && timer == 16'd1))
				flush_tmo <= 1'b1;
			else if (wback_start)
				flush_tmo <= 1'b0;
		end
	end

endmodule

//--- design/rxd_local_queues.sv
module rxd_local_queues #(
	parameter int DESC_RAM_DWORDS = 1024
) (
	input  logic                 aclk,
	input  logic                 aresetn,
	input  logic                 in_enq,
	input  rxd_pkg::desc_cnt_t   in_enq_incr,
	input  logic                 in_deq,
	input  logic                 out_enq,
	input  logic                 out_deq,
	input  rxd_pkg::desc_cnt_t   out_deq_incr,
	output rxd_pkg::desc_cnt_t   in_num,
	output rxd_pkg::desc_cnt_t   out_num,
	output rxd_pkg::desc_cnt_t   local_pending,
	output rxd_pkg::desc_cnt_t   local_available,
	output rxd_pkg::local_addr_t fetch_local_address,
	output rxd_pkg::local_addr_t wb_local_address,
	output rxd_pkg::local_addr_t eng_local_address
);
	import rxd_pkg::*;

	localparam int SLOTS = DESC_RAM_DWORDS / 4;
	localparam int SLOT_BITS = $clog2(SLOTS);

	// in_tail is the next free slot, in_head the next one for the engine,
	// out_head the oldest completed slot
	logic [SLOT_BITS-1:0] in_tail;
	logic [SLOT_BITS-1:0] in_head;
	logic [SLOT_BITS-1:0] out_head;
	desc_cnt_t            enq_cnt;
	desc_cnt_t            deq_cnt;

	assign enq_cnt = in_enq ? in_enq_incr : '0;
	assign deq_cnt = out_deq ? out_deq_incr : '0;

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			in_tail <= '0;
			in_head <= '0;
			out_head <= '0;
			in_num <= '0;
			out_num <= '0;
			local_pending <= '0;
			local_available <= desc_cnt_t'(SLOTS);
		end else begin
			if (in_enq)
				in_tail <= in_tail + in_enq_incr[SLOT_BITS-1:0];
			if (in_deq)
				in_head <= in_head + 1'b1;
			if (out_deq)
				out_head <= out_head + out_deq_incr[SLOT_BITS-1:0];
			in_num <= in_num + enq_cnt - desc_cnt_t'(in_deq);
			out_num <= out_num + desc_cnt_t'(out_enq) - deq_cnt;
			// Slots stay held from fetch until write-back
			local_pending <= local_pending + enq_cnt - deq_cnt;
			local_available <= local_available - enq_cnt + deq_cnt;
		end
	end

	assign fetch_local_address = local_addr_t'(in_tail) << DESC_BYTES_LOG2;
	assign wb_local_address = local_addr_t'(out_head) << DESC_BYTES_LOG2;
	assign eng_local_address = local_addr_t'(in_head) << DESC_BYTES_LOG2;

endmodule

//--- design/rxd_pkg.sv
package rxd_pkg;

	// Descriptor index or count within the host ring
	typedef logic [15:0] host_idx_t;
	typedef logic [63:0] host_addr_t;
	// Byte address into the local descriptor memory
	typedef logic [15:0] local_addr_t;
	typedef logic [15:0] byte_cnt_t;
	// Local slot count or index, up to 256 slots
	typedef logic [8:0]  desc_cnt_t;

	// 16-byte descriptors
	localparam int DESC_BYTES_LOG2 = 4;

	typedef enum logic [3:0] {
		FS_IDLE,
		FS_READY,
		FS_WBACK,
		FS_WBACK_WAIT,
		FS_DEQUEUE,
		FS_SET_SIZE,
		FS_FETCH,
		FS_FETCH_WAIT,
		FS_ENQUEUE,
		FS_SETTLE
	} fetch_state_t;

	typedef enum logic [2:0] {
		ES_IDLE,
		ES_READY,
		ES_CMD,
		ES_DEQUEUE,
		ES_WAIT,
		ES_ENQUEUE
	} eng_state_t;

endpackage

//--- design/rxd_ring_regs.sv
module rxd_ring_regs (
	input  logic                aclk,
	input  logic                aresetn,
	input  rxd_pkg::host_addr_t rdba,
	input  logic [12:0]         rdlen,
	input  rxd_pkg::host_idx_t  rdh,
	input  rxd_pkg::host_idx_t  rdt,
	input  logic                rdh_set,
	input  logic                rdt_set,
	input  logic                head_adv,
	input  logic                curr_adv,
	input  rxd_pkg::host_idx_t  head_incr,
	input  rxd_pkg::host_idx_t  curr_incr,
	output rxd_pkg::host_idx_t  rdh_fb,
	output rxd_pkg::host_idx_t  host_fresh,
	output rxd_pkg::host_idx_t  fetch_limit,
	output rxd_pkg::host_idx_t  wback_limit,
	output rxd_pkg::host_addr_t host_rd_address,
	output rxd_pkg::host_addr_t host_wb_address,
	output logic                ptrs_busy
);
	import rxd_pkg::*;

	host_idx_t   ring_len;
	host_idx_t   head;
	host_idx_t   curr;
	host_idx_t   tail;
	logic        ptr_event;
	logic [4:0]  calc_stage;
	logic [16:0] head_n0;
	logic [16:0] curr_n0;
	host_idx_t   head_n1;
	host_idx_t   curr_n1;
	logic [16:0] fresh_n0;
	logic [16:0] fresh_n1;
	host_idx_t   fresh_n2;

	// Fold a value below twice the ring length back into the ring
	function automatic host_idx_t wrap_idx(input logic [16:0] value, input host_idx_t len);
		logic [16:0] ext_len;
		ext_len = {1'b0, len};
		if (value >= ext_len)
			return host_idx_t'(value - ext_len);
		return host_idx_t'(value);
	endfunction

	// Eight descriptors per rdlen unit
	assign ring_len = {rdlen, 3'b000};
	assign ptr_event = rdh_set | rdt_set | head_adv | curr_adv;
	assign ptrs_busy = ptr_event | (|calc_stage);
	assign rdh_fb = head;

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn)
			calc_stage <= '0;
		else
			calc_stage <= {calc_stage[3:0], ptr_event};
	end

	// Stage 0 sums hold the latest pointer targets between events
	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			head_n0 <= '0;
			curr_n0 <= '0;
		end else begin
			if (rdh_set)
				head_n0 <= {1'b0, rdh};
			else if (head_adv)
				head_n0 <= {1'b0, head} + {1'b0, head_incr};

			if (rdh_set)
				curr_n0 <= {1'b0, rdh};
			else if (curr_adv)
				curr_n0 <= {1'b0, curr} + {1'b0, curr_incr};
		end
	end

	// Stage 1 wrap, then the fresh count over stages 2 to 4
	always_ff @(posedge aclk) begin
		if (calc_stage[0]) begin
			head_n1 <= wrap_idx(head_n0, ring_len);
			curr_n1 <= wrap_idx(curr_n0, ring_len);
		end
		if (calc_stage[1])
			fresh_n0 <= {1'b0, tail} + {1'b0, ring_len};
		if (calc_stage[2])
			fresh_n1 <= fresh_n0 - {1'b0, curr};
		if (calc_stage[3])
			fresh_n2 <= wrap_idx(fresh_n1, ring_len);
	end

	always_ff @(posedge aclk or negedge aresetn) begin
		if (!aresetn) begin
			head <= '0;
			curr <= '0;
			tail <= '0;
			fetch_limit <= '0;
			wback_limit <= '0;
			host_fresh <= '0;
		end else begin
			if (rdt_set)
				tail <= rdt;
			if (calc_stage[1]) begin
				head <= head_n1;
				curr <= curr_n1;
			end
			// Descriptors left before each pointer wraps
			if (calc_stage[2]) begin
				fetch_limit <= ring_len - curr;
				wback_limit <= ring_len - head;
			end
			if (calc_stage[4])
				host_fresh <= fresh_n2;
		end
	end

	always_ff @(posedge aclk) begin
		host_rd_address <= rdba + (host_addr_t'(curr) << DESC_BYTES_LOG2);
		host_wb_address <= rdba + (host_addr_t'(head) << DESC_BYTES_LOG2);
	end

endmodule

//--- sim.f
design/rxd_pkg.sv
design/rxd_ring_regs.sv
design/rxd_local_queues.sv
design/rxd_flush_timer.sv
design/rxd_dma_sched.sv
design/rxd_engine_dispatch.sv
design/rx_desc_ctrl.sv
test/rxd_asserts.sv
test/rxd_checker.sv
test/rx_desc_ctrl_tb.sv

//--- test/rx_desc_ctrl_tb.sv
module rx_desc_ctrl_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import rxd_pkg::*;

	localparam int TOTAL_DESC = 40;
	localparam int RING = 16;
	localparam int WAIT_LIMIT = 5000;
	localparam int DRAIN_LIMIT = 20000;

	logic        aclk;
	logic        aresetn;
	logic        en;
	host_addr_t  rdba;
	logic [12:0] rdlen;
	host_idx_t   rdh;
	logic        rdh_set;
	host_idx_t   rdh_fb;
	host_idx_t   rdt;
	logic        rdt_set;
	logic [5:0]  pthresh;
	logic [5:0]  hthresh;
	logic [5:0]  wthresh;
	logic [15:0] rdtr;
	logic        rxt0_req;
	host_addr_t  idma_src_addr;
	local_addr_t idma_dst_addr;
	byte_cnt_t   idma_bytes;
	logic        idma_valid;
	logic        idma_ready;
	logic        irpt_valid;
	local_addr_t odma_src_addr;
	host_addr_t  odma_dst_addr;
	byte_cnt_t   odma_bytes;
	logic        odma_valid;
	logic        odma_ready;
	logic        orpt_valid;
	logic [31:0] reng_m_tdata;
	logic        reng_m_tvalid;
	logic        reng_m_tready;
	logic        reng_s_tvalid;
	logic        reng_s_tlast;
	logic        reng_s_tready;

	int posted;
	int timeouts;
	int idma_dly;
	int idma_rpt;
	int odma_dly;
	int odma_rpt;
	int cmd_dly;
	int done_dly;

	rx_desc_ctrl #(
		.DESC_RAM_DWORDS(32),
		.CLK_PERIOD_NS(4)
	) i_rx_desc_ctrl (.*);

	rxd_checker i_checker (.*);

	always #2 aclk = ~aclk;

	// Fetch DMA: ready after a random delay, report 1 to 6 cycles later
	always @(posedge aclk) begin
		irpt_valid <= 1'b0;
		if (idma_valid && idma_ready) begin
			idma_ready <= 1'b0;
			idma_rpt <= 1 + $urandom % 6;
			idma_dly <= $urandom % 4;
		end else if (idma_valid) begin
			if (idma_dly == 0)
				idma_ready <= 1'b1;
			else
				idma_dly <= idma_dly - 1;
		end
		if (idma_rpt == 1)
			irpt_valid <= 1'b1;
		if (idma_rpt != 0)
			idma_rpt <= idma_rpt - 1;
	end

	// Write-back DMA, same behavior
	always @(posedge aclk) begin
		orpt_valid <= 1'b0;
		if (odma_valid && odma_ready) begin
			odma_ready <= 1'b0;
			odma_rpt <= 1 + $urandom % 6;
			odma_dly <= $urandom % 4;
		end else if (odma_valid) begin
			if (odma_dly == 0)
				odma_ready <= 1'b1;
			else
				odma_dly <= odma_dly - 1;
		end
		if (odma_rpt == 1)
			orpt_valid <= 1'b1;
		if (odma_rpt != 0)
			odma_rpt <= odma_rpt - 1;
	end

	// Receive engine model
	always @(posedge aclk) begin
		if (reng_m_tvalid && reng_m_tready) begin
			reng_m_tready <= 1'b0;
			cmd_dly <= $urandom % 4;
		end else if (reng_m_tvalid) begin
			if (cmd_dly == 0)
				reng_m_tready <= 1'b1;
			else
				cmd_dly <= cmd_dly - 1;
		end
		if (reng_s_tvalid && reng_s_tready) begin
			reng_s_tvalid <= 1'b0;
			reng_s_tlast <= 1'b0;
			done_dly <= $urandom % 20;
		end else if (reng_s_tready && !reng_s_tvalid) begin
			if (done_dly == 0) begin
				reng_s_tvalid <= 1'b1;
				reng_s_tlast <= 1'b1;
			end else begin
				done_dly <= done_dly - 1;
			end
		end
	end

	task automatic idle_cycles(input int n);
		repeat (n) @(posedge aclk);
	endtask

	task automatic post_descriptors(input int n);
		@(posedge aclk);
		rdt <= host_idx_t'((posted + n) % RING);
		rdt_set <= 1'b1;
		posted = posted + n;
		@(posedge aclk);
		rdt_set <= 1'b0;
	endtask

	task automatic wait_ring_room();
		int t;
		t = 0;
		while (posted - i_checker.wb_total >= RING - 1 && t < WAIT_LIMIT) begin
			@(posedge aclk);
			t++;
		end
		if (t >= WAIT_LIMIT) begin
			timeouts++;
			$display("Timeout at %0t: ring stayed full, no write-back", $time);
		end
	endtask

	task automatic wait_fetch_start();
		int t;
		t = 0;
		while (!idma_valid && t < WAIT_LIMIT) begin
			@(posedge aclk);
			t++;
		end
		if (t >= WAIT_LIMIT) begin
			timeouts++;
			$display("Timeout at %0t: no fetch after enabling", $time);
		end
	endtask

	task automatic wait_drained();
		int t;
		t = 0;
		while ((rdh_fb != rdt || i_checker.wb_total != TOTAL_DESC) && t < DRAIN_LIMIT) begin
			@(posedge aclk);
			t++;
		end
		if (t >= DRAIN_LIMIT) begin
			timeouts++;
			$display("Timeout at %0t: ring did not drain", $time);
		end
	endtask

	initial begin
		int step;
		int room;
		int total_errors;
		void'($urandom(32'h9aec_7b78));
		aclk = 1'b0;
		aresetn = 1'b0;
		en = 1'b0;
		rdba = 64'h1000_0000;
		rdlen = 13'd2;
		rdh = '0;
		rdh_set = 1'b0;
		rdt = '0;
		rdt_set = 1'b0;
		pthresh = 6'd0;
		hthresh = 6'd0;
		wthresh = 6'd2;
		rdtr = 16'd1;
		idma_ready = 1'b0;
		irpt_valid = 1'b0;
		odma_ready = 1'b0;
		orpt_valid = 1'b0;
		reng_m_tready = 1'b0;
		reng_s_tvalid = 1'b0;
		reng_s_tlast = 1'b0;
		idma_dly = 0;
		idma_rpt = 0;
		odma_dly = 0;
		odma_rpt = 0;
		cmd_dly = 0;
		done_dly = 0;
		posted = 0;
		timeouts = 0;
		idle_cycles(16);
		aresetn <= 1'b1;
		idle_cycles(4);

		// Descriptors posted while disabled must stay untouched
		post_descriptors(4);
		idle_cycles(40);
		en <= 1'b1;
		wait_fetch_start();

		while (posted < TOTAL_DESC && timeouts == 0) begin
			wait_ring_room();
			step = 1 + $urandom % 4;
			room = RING - 1 - (posted - i_checker.wb_total);
			if (step > room)
				step = room;
			if (step > TOTAL_DESC - posted)
				step = TOTAL_DESC - posted;
			if (step > 0)
				post_descriptors(step);
			idle_cycles($urandom % 40);
		end

		wait_drained();
		idle_cycles(300);
		i_checker.check_totals(TOTAL_DESC, rdt);

		total_errors = i_checker.mismatches + i_checker.failures + timeouts +
			i_rx_desc_ctrl.i_asserts.fail_count;
		$display("Errors: %0d mismatches, %0d other failures, %0d timeouts, %0d assertions",
			i_checker.mismatches, i_checker.failures, timeouts,
			i_rx_desc_ctrl.i_asserts.fail_count);
		if (total_errors == 0)
			$display("ALL TESTS PASSED");
		else
			$display("SOME TESTS FAILED");
		$finish;
	end

endmodule

//--- test/rxd_asserts.sv
module rxd_asserts (
	input logic        aclk,
	input logic        aresetn,
	input logic        idma_valid,
	input logic        idma_ready,
	input logic [63:0] idma_src_addr,
	input logic [15:0] idma_dst_addr,
	input logic [15:0] idma_bytes,
	input logic        odma_valid,
	input logic        odma_ready,
	input logic [15:0] odma_src_addr,
	input logic [63:0] odma_dst_addr,
	input logic [15:0] odma_bytes,
	input logic        reng_m_tvalid,
	input logic        reng_m_tready,
	input logic [31:0] reng_m_tdata,
	input logic        rxt0_req
);
	timeunit 1ns;
	timeprecision 1ps;

	int fail_count = 0;

	// Commands held until accepted
	idma_hold: assert property (@(posedge aclk) disable iff (!aresetn)
		idma_valid && !idma_ready |=> idma_valid && $stable(idma_src_addr) &&
		$stable(idma_dst_addr) && $stable(idma_bytes))
		else begin
			fail_count++;
			$error("Fetch command changed before ready");
		end

	odma_hold: assert property (@(posedge aclk) disable iff (!aresetn)
		odma_valid && !odma_ready |=> odma_valid && $stable(odma_src_addr) &&
		$stable(odma_dst_addr) && $stable(odma_bytes))
		else begin
			fail_count++;
			$error("Write-back command changed before ready");
		end

	eng_hold: assert property (@(posedge aclk) disable iff (!aresetn)
		reng_m_tvalid && !reng_m_tready |=> reng_m_tvalid && $stable(reng_m_tdata))
		else begin
			fail_count++;
			$error("Engine command changed before ready");
		end

	irq_pulse: assert property (@(posedge aclk) disable iff (!aresetn)
		rxt0_req |=> !rxt0_req)
		else begin
			fail_count++;
			$error("Interrupt pulse longer than one cycle");
		end

endmodule

bind rx_desc_ctrl rxd_asserts i_asserts (
	.aclk(aclk),
	.aresetn(aresetn),
	.idma_valid(idma_valid),
	.idma_ready(idma_ready),
	.idma_src_addr(idma_src_addr),
	.idma_dst_addr(idma_dst_addr),
	.idma_bytes(idma_bytes),
	.odma_valid(odma_valid),
	.odma_ready(odma_ready),
	.odma_src_addr(odma_src_addr),
	.odma_dst_addr(odma_dst_addr),
	.odma_bytes(odma_bytes),
	.reng_m_tvalid(reng_m_tvalid),
	.reng_m_tready(reng_m_tready),
	.reng_m_tdata(reng_m_tdata),
	.rxt0_req(rxt0_req)
);

//--- test/rxd_checker.sv
module rxd_checker (
	input logic        aclk,
	input logic        aresetn,
	input logic        en,
	input logic [15:0] rdt,
	input logic        rdt_set,
	input logic [15:0] rdh_fb,
	input logic [63:0] idma_src_addr,
	input logic [15:0] idma_dst_addr,
	input logic [15:0] idma_bytes,
	input logic        idma_valid,
	input logic        idma_ready,
	input logic [15:0] odma_src_addr,
	input logic [63:0] odma_dst_addr,
	input logic [15:0] odma_bytes,
	input logic        odma_valid,
	input logic        odma_ready,
	input logic        orpt_valid,
	input logic        rxt0_req,
	input logic [31:0] reng_m_tdata,
	input logic        reng_m_tvalid,
	input logic        reng_m_tready,
	input logic        reng_s_tvalid,
	input logic        reng_s_tlast,
	input logic        reng_s_tready
);
	timeunit 1ns;
	timeprecision 1ps;

	localparam int RING = 16;
	localparam int SLOTS = 8;
	localparam longint BASE = 64'h1000_0000;

	int mismatches = 0;
	int failures = 0;
	int wb_total;
	int tail;
	int tail_prev;
	int curr;
	int head;
	int fetch_slot;
	int wb_slot;
	int held;
	int done;
	int done_d1;
	int done_d2;
	int done_d3;
	int reports;
	int irqs;
	bit idma_open;
	bit odma_open;
	int slot_q[$];

	// Transfer size: stop at the ring end, at the ready count and at the room
	function automatic int ref_count(input int ptr, input int ready_cnt, input int room);
		int n;
		n = RING - ptr;
		if (ready_cnt < n)
			n = ready_cnt;
		if (room < n)
			n = room;
		return n;
	endfunction

	task automatic note_mismatch(input string what, input longint got, input longint exp);
		if (got != exp) begin
			mismatches++;
			$display("Mismatch at %0t: %s is %0h, expected %0h", $time, what, got, exp);
		end
	endtask

	task automatic check_totals(input int posted, input logic [15:0] final_tail);
		note_mismatch("final head", rdh_fb, final_tail);
		note_mismatch("descriptors written back", wb_total, posted);
		note_mismatch("descriptors completed", done, posted);
		note_mismatch("interrupt pulses", irqs, reports);
		if (reports == 0) begin
			failures++;
			$display("No write-back report was seen");
		end
	endtask

	always @(posedge aclk) begin : compare
		int n;
		int exp_slot;
		if (!aresetn) begin
			wb_total = 0;
			tail = 0;
			tail_prev = 0;
			curr = 0;
			head = 0;
			fetch_slot = 0;
			wb_slot = 0;
			held = 0;
			done = 0;
			done_d1 = 0;
			done_d2 = 0;
			done_d3 = 0;
			reports = 0;
			irqs = 0;
			idma_open = 0;
			odma_open = 0;
			slot_q.delete();
		end else begin
			if (!en && (idma_valid || odma_valid || reng_m_tvalid)) begin
				failures++;
				$display("A valid output rose at %0t while en was low", $time);
			end

			// Tail seen by the fetch decision two cycles back
			if (idma_valid && !idma_open) begin
				idma_open = 1;
				n = ref_count(curr, (tail_prev - curr + RING) % RING, SLOTS - held);
				if (n == 0) begin
					failures++;
					$display("A fetch was issued at %0t with nothing to fetch", $time);
				end
				note_mismatch("fetch source", idma_src_addr, BASE + curr * 16);
				note_mismatch("fetch destination", idma_dst_addr, fetch_slot * 16);
				note_mismatch("fetch bytes", idma_bytes, n * 16);
				for (int i = 0; i < n; i++)
					slot_q.push_back(((fetch_slot + i) % SLOTS) * 16);
				curr = (curr + n) % RING;
				fetch_slot = (fetch_slot + n) % SLOTS;
				held = held + n;
			end
			if (idma_valid && idma_ready)
				idma_open = 0;

			// Completions counted three cycles before the first valid cycle
			if (odma_valid && !odma_open) begin
				odma_open = 1;
				n = ref_count(head, done_d3 - wb_total, SLOTS);
				note_mismatch("write-back source", odma_src_addr, wb_slot * 16);
				note_mismatch("write-back destination", odma_dst_addr, BASE + head * 16);
				note_mismatch("write-back bytes", odma_bytes, n * 16);
				head = (head + n) % RING;
				wb_slot = (wb_slot + n) % SLOTS;
				held = held - n;
				wb_total = wb_total + n;
			end
			if (odma_valid && odma_ready)
				odma_open = 0;

			if (reng_m_tvalid && reng_m_tready) begin
				if (slot_q.size() == 0) begin
					failures++;
					$display("Engine command at %0t without a fetched descriptor", $time);
				end else begin
					exp_slot = slot_q.pop_front();
					note_mismatch("engine slot address", reng_m_tdata, exp_slot);
				end
			end

			if (orpt_valid)
				reports++;
			if (rxt0_req)
				irqs++;

			done_d3 = done_d2;
			done_d2 = done_d1;
			if (reng_s_tvalid && reng_s_tlast && reng_s_tready)
				done++;
			done_d1 = done;
			tail_prev = tail;
			if (rdt_set)
				tail = rdt;
		end
	end

endmodule
